//--- tb.f
lattice_pkg.sv
protocol_pkg.sv
stage_tracker.sv
root_elect.sv
direct_msg_unit.sv
cluster_state.sv
processing_unit.sv
tb_pu_chk.sv
tb_processing_unit.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and pass only if the testbench reports a pass
verilator --binary --timing --assert --top-module tb_processing_unit -f tb.f \
    && ./obj_dir/Vtb_processing_unit | grep -F '*** TEST PASSED ***' \
    || { echo 'simulation did not pass'; exit 1; }

//--- tb_processing_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_processing_unit;
    import lattice_pkg::*;
    import protocol_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 4;
    localparam addr_t own_addr   = '{k: 8'd2, i: 5'd1, j: 5'd0}; // node (2, 1, 0)
    localparam addr_t small_root = '{k: 8'd1, i: 5'd3, j: 5'd4}; // beats own address
    localparam addr_t large_root = '{k: 8'd3, i: 5'd0, j: 5'd0}; // loses to it
    localparam direct_msg_t msg_join = '{
        receiver: small_root, is_odd_cardinality: 1'b1, is_touching_boundary: 1'b0};
    localparam direct_msg_t msg_touch = '{
        receiver: small_root, is_odd_cardinality: 1'b0, is_touching_boundary: 1'b1};

    // exp bits from the top are valid, increase, taken[2:0], card, touch, odd cluster,
    // busy, root and old root
    typedef struct packed {
        stage_e      stage;
        logic [5:0]  grown;
        logic [5:0]  nodd;
        logic        full;
        logic [2:0]  vin;
        logic [10:0] exp;
        direct_msg_t exp_msg; // only compared while valid is expected
    } row_t;

    logic        clk, reset;
    stage_e      stage_in;
    logic        init_is_error_syndrome;
    logic [5:0]  neighbor_is_fully_grown, neighbor_is_odd_cluster;
    addr_t       neighbor_roots [6];
    logic        neighbor_increase, direct_out_valid, direct_out_is_full;
    direct_msg_t direct_out_msg;
    direct_msg_t direct_in_msgs [3];
    logic [2:0]  direct_in_valid, direct_in_is_taken;
    addr_t       old_root, updated_root;
    logic        is_error_syndrome, is_odd_cluster, is_touching_boundary;
    logic        is_odd_cardinality, is_processing;
    row_t        rows [$];
    logic [31:0] rng;
    int          error_count;
    logic        table_ready;

    processing_unit #(
        .I(1), .J(0), .K(2),
        .CODE_DISTANCE_Z(4), .BOUNDARY_COST_Z(2), .BOUNDARY_COST_UD(2)
    ) i_dut (.*);

    bind processing_unit tb_pu_chk #(.DIRECT_CHANNEL_COUNT(DIRECT_CHANNEL_COUNT)) i_pu_chk (
        .clk(clk), .reset(reset), .neighbor_increase(neighbor_increase),
        .direct_out_msg(direct_out_msg), .direct_out_valid(direct_out_valid),
        .direct_out_is_full(direct_out_is_full), .direct_in_valid(direct_in_valid),
        .direct_in_is_taken(direct_in_is_taken)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input stage_e st, input logic [5:0] grown, input logic [5:0] nodd,
                           input logic full, input logic [2:0] vin, input logic [10:0] exp,
                           input direct_msg_t msg);
        rows.push_back('{st, grown, nodd, full, vin, exp, msg});
    endtask

    task automatic build_table();
        add_row(measurement_loading, 6'h00, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0000_00, '0);
        add_row(measurement_loading, 6'h00, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0000_00, '0);
        add_row(idle,                6'h00, 6'h00, 1'b0, 3'b000, 11'b0_0_000_1010_00, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_1010_00, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b1, 3'b000, 11'b0_0_000_1011_00, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b1, 3'b000, 11'b1_0_000_1011_10, msg_join);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b1, 3'b000, 11'b1_0_000_1011_10, msg_join);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b1, 3'b000, 11'b1_0_000_1011_10, msg_join);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b000, 11'b1_0_000_1011_10, msg_join);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b011, 11'b0_0_001_1011_10, '0);
        add_row(grow_boundary,       6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0010_10, '0);
        add_row(grow_boundary,       6'h03, 6'h00, 1'b0, 3'b000, 11'b0_1_000_0010_10, '0);
        add_row(idle,                6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0010_10, '0);
        add_row(grow_boundary,       6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0010_10, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b000, 11'b0_1_000_0010_10, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0010_10, '0);
        add_row(spread_cluster,      6'h03, 6'h00, 1'b0, 3'b000, 11'b1_0_000_0111_10, msg_touch);
        add_row(sync_is_odd_cluster, 6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0110_10, '0);
        add_row(sync_is_odd_cluster, 6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0111_10, '0);
        add_row(sync_is_odd_cluster, 6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0101_11, '0);
        add_row(sync_is_odd_cluster, 6'h03, 6'h04, 1'b0, 3'b000, 11'b0_0_000_0101_11, '0);
        add_row(idle,                6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0111_11, '0);
        add_row(idle,                6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0110_11, '0);
        add_row(idle,                6'h03, 6'h00, 1'b0, 3'b000, 11'b0_0_000_0110_11, '0);
    endtask

    task automatic apply_row(input row_t rw);
        addr_t r;
        stage_in                = rw.stage;
        neighbor_is_fully_grown = rw.grown;
        neighbor_is_odd_cluster = rw.nodd;
        direct_out_is_full      = rw.full;
        direct_in_valid         = rw.vin;
        for (int n = 2; n < 6; n++) begin // neighbours never grown get noise roots
            rng = xorshift(rng);
            r = addr_t'(rng[17:0]);
            r.k[7] = 1'b1; // keeps it above own address
            neighbor_roots[n] = r;
        end
    endtask

    task automatic check_row(input int r, input row_t rw);
        logic [10:0] e;
        e = rw.exp;
        check($sformatf("row %0d direct_out_valid", r), 32'(direct_out_valid), 32'(e[10]));
        check($sformatf("row %0d neighbor_increase", r), 32'(neighbor_increase), 32'(e[9]));
        check($sformatf("row %0d direct_in_is_taken", r), 32'(direct_in_is_taken), 32'(e[8:6]));
        check($sformatf("row %0d is_odd_cardinality", r), 32'(is_odd_cardinality), 32'(e[5]));
        check($sformatf("row %0d is_touching_boundary", r), 32'(is_touching_boundary), 32'(e[4]));
        check($sformatf("row %0d is_odd_cluster", r), 32'(is_odd_cluster), 32'(e[3]));
        check($sformatf("row %0d is_processing", r), 32'(is_processing), 32'(e[2]));
        check($sformatf("row %0d updated_root", r), 32'(updated_root),
              32'(e[1] ? small_root : own_addr));
        check($sformatf("row %0d old_root", r), 32'(old_root), 32'(e[0] ? small_root : own_addr));
        if (e[10])
            check($sformatf("row %0d direct_out_msg", r), 32'(direct_out_msg), 32'(rw.exp_msg));
    endtask

    initial begin
        wait (table_ready);
        #((reset_cycles + rows.size() + 8) * clk_period);
        $display("watchdog expired before the stimulus table finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        reset                   = 1'b1;
        stage_in                = idle;
        init_is_error_syndrome  = 1'b1; // every table row loads syndrome 1
        neighbor_is_fully_grown = '0;
        neighbor_is_odd_cluster = '0;
        direct_out_is_full      = 1'b0;
        direct_in_valid         = '0;
        neighbor_roots[0]       = small_root;
        neighbor_roots[1]       = large_root;
        for (int n = 2; n < 6; n++)
            neighbor_roots[n] = large_root;
        direct_in_msgs[0] = '{receiver: own_addr, is_odd_cardinality: 1'b1,
                              is_touching_boundary: 1'b0}; // for this node
        direct_in_msgs[1] = '{receiver: large_root, is_odd_cardinality: 1'b1,
                              is_touching_boundary: 1'b1}; // passing through and left untaken
        direct_in_msgs[2] = '0;
        rng         = 32'hdc3f;
        error_count = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check("reset control outputs", 32'({neighbor_increase, direct_out_valid,
              direct_in_is_taken, is_processing}), 32'(0));
        check("reset updated_root", 32'(updated_root), 32'(own_addr));
        check("reset old_root", 32'(old_root), 32'(own_addr));
        check("reset is_error_syndrome", 32'(is_error_syndrome), 32'(0));
        foreach (rows[r]) begin
            @(negedge clk);
            apply_row(rows[r]);
            #1; // outputs settled in the low phase
            check_row(r, rows[r]);
        end
        // syndrome stays loaded while the cardinality has flipped back to even
        check("loaded is_error_syndrome", 32'(is_error_syndrome), 32'(1));
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_pu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pu_chk #(
    parameter int DIRECT_CHANNEL_COUNT = 3
) (
    input logic                            clk,
    input logic                            reset,
    input logic                            neighbor_increase,
    input protocol_pkg::direct_msg_t       direct_out_msg,
    input logic                            direct_out_valid,
    input logic                            direct_out_is_full,
    input logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_valid,
    input logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_is_taken
);

    // growth request is one pulse per grow stage
    inc_single_pulse: assert property (@(posedge clk) disable iff (reset)
        neighbor_increase |=> !neighbor_increase)
        else $error("neighbor_increase high in two consecutive cycles");

    // blocked own message waits in place, unchanged
    out_held: assert property (@(posedge clk) disable iff (reset)
        direct_out_valid && direct_out_is_full |=> direct_out_valid && $stable(direct_out_msg))
        else $error("direct_out message dropped or changed while blocked");

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (direct_in_is_taken & ~direct_in_valid) == '0) // only a carried message is taken
        else $error("direct_in_is_taken raised on an empty channel");

endmodule

`default_nettype wire

//--- processing_unit.sv
`timescale 1ns/1ps
`default_nettype none

module processing_unit #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0,
    parameter int CODE_DISTANCE_Z = 12,
    parameter int BOUNDARY_COST_Z = 2,
    parameter int BOUNDARY_COST_UD = 2,
    parameter int NEIGHBOR_COUNT = 6,
    parameter int DIRECT_CHANNEL_COUNT = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  protocol_pkg::stage_e            stage_in,
    input  logic                            init_is_error_syndrome,
    input  logic [NEIGHBOR_COUNT-1:0]       neighbor_is_fully_grown,
    input  logic [NEIGHBOR_COUNT-1:0]       neighbor_is_odd_cluster,
    input  lattice_pkg::addr_t              neighbor_roots [NEIGHBOR_COUNT],
    output logic                            neighbor_increase,
    output protocol_pkg::direct_msg_t       direct_out_msg,
    output logic                            direct_out_valid,
    input  logic                            direct_out_is_full,
    input  protocol_pkg::direct_msg_t       direct_in_msgs [DIRECT_CHANNEL_COUNT],
    input  logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_valid,
    output logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_is_taken,
    output lattice_pkg::addr_t              old_root,
    output lattice_pkg::addr_t              updated_root,
    output logic                            is_error_syndrome,
    output logic                            is_odd_cluster,
    output logic                            is_touching_boundary,
    output logic                            is_odd_cardinality,
    output logic                            is_processing
);
    import lattice_pkg::*;
    import protocol_pkg::*;

    stage_e stage;
    logic   stage_entry;
    addr_t  new_root;     // combinational election result
    logic   root_changed; // only raised while spreading
    logic   next_touching;
    logic   gathered_odd, gathered_touching; // absorbed from messages to this node
    logic   msg_busy;

    stage_tracker i_stage_tracker (
        .clk         (clk),
        .reset       (reset),
        .stage_in    (stage_in),
        .stage       (stage),
        .stage_entry (stage_entry)
    );

    root_elect #(
        .I(I), .J(J), .K(K),
        .NEIGHBOR_COUNT(NEIGHBOR_COUNT)
    ) i_root_elect (
        .clk                     (clk),
        .reset                   (reset),
        .stage                   (stage),
        .stage_entry             (stage_entry),
        .neighbor_is_fully_grown (neighbor_is_fully_grown),
        .neighbor_roots          (neighbor_roots),
        .new_root                (new_root),
        .root_changed            (root_changed),
        .updated_root            (updated_root),
        .old_root                (old_root)
    );

    direct_msg_unit #(
        .I(I), .J(J), .K(K),
        .DIRECT_CHANNEL_COUNT(DIRECT_CHANNEL_COUNT)
    ) i_direct_msg_unit (
        .clk                  (clk),
        .reset                (reset),
        .stage                (stage),
        .new_root             (new_root),
        .root_changed         (root_changed),
        .is_error_syndrome    (is_error_syndrome),
        .is_touching_boundary (is_touching_boundary),
        .next_touching        (next_touching),
        .direct_in_msgs       (direct_in_msgs),
        .direct_in_valid      (direct_in_valid),
        .direct_in_is_taken   (direct_in_is_taken),
        .direct_out_msg       (direct_out_msg),
        .direct_out_valid     (direct_out_valid),
        .direct_out_is_full   (direct_out_is_full),
        .gathered_odd         (gathered_odd),
        .gathered_touching    (gathered_touching),
        .msg_busy             (msg_busy)
    );

    cluster_state #(
        .I(I), .J(J), .K(K),
        .CODE_DISTANCE_Z(CODE_DISTANCE_Z),
        .BOUNDARY_COST_Z(BOUNDARY_COST_Z),
        .BOUNDARY_COST_UD(BOUNDARY_COST_UD),
        .NEIGHBOR_COUNT(NEIGHBOR_COUNT)
    ) i_cluster_state (
        .clk                     (clk),
        .reset                   (reset),
        .stage                   (stage),
        .stage_entry             (stage_entry),
        .init_is_error_syndrome  (init_is_error_syndrome),
        .gathered_odd            (gathered_odd),
        .gathered_touching       (gathered_touching),
        .root_changed            (root_changed),
        .msg_busy                (msg_busy),
        .updated_root            (updated_root),
        .neighbor_is_odd_cluster (neighbor_is_odd_cluster),
        .is_error_syndrome       (is_error_syndrome),
        .is_odd_cardinality      (is_odd_cardinality),
        .is_touching_boundary    (is_touching_boundary),
        .next_touching           (next_touching),
        .is_odd_cluster          (is_odd_cluster),
        .neighbor_increase       (neighbor_increase),
        .is_processing           (is_processing)
    );

endmodule

`default_nettype wire

//--- cluster_state.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_state #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0,
    parameter int CODE_DISTANCE_Z = 12,
    parameter int BOUNDARY_COST_Z = 2,
    parameter int BOUNDARY_COST_UD = 2,
    parameter int NEIGHBOR_COUNT = 6
) (
    input  logic                      clk,
    input  logic                      reset,
    input  protocol_pkg::stage_e      stage,
    input  logic                      stage_entry,
    input  logic                      init_is_error_syndrome,
    input  logic                      gathered_odd,
    input  logic                      gathered_touching,
    input  logic                      root_changed,
    input  logic                      msg_busy,
    input  lattice_pkg::addr_t        updated_root,
    input  logic [NEIGHBOR_COUNT-1:0] neighbor_is_odd_cluster,
    output logic                      is_error_syndrome,
    output logic                      is_odd_cardinality,
    output logic                      is_touching_boundary,
    output logic                      next_touching,
    output logic                      is_odd_cluster,
    output logic                      neighbor_increase,
    output logic                      is_processing
);
    import lattice_pkg::*;
    import protocol_pkg::*;

    localparam addr_t own_addr = make_addr(K, I, J);
    // Z boundary on the first and last column, up-down boundary on the first round
    localparam bit    has_z   = (J == 0) || (J == CODE_DISTANCE_Z - 1);
    localparam bit    has_ud  = (K == 0);
    localparam cost_t cost_z  = cost_t'(BOUNDARY_COST_Z);
    localparam cost_t cost_ud = cost_t'(BOUNDARY_COST_UD);

    cost_t grown_z, grown_ud;  // boundary growth so far
    logic  odd_root;           // root of an odd cluster off the boundary
    logic  next_odd_cluster;
    logic  grow_now;
    logic  changed, changed_d; // neighbour-visible change, and its echo

    assign next_touching = is_touching_boundary
                        || (has_z && grown_z == cost_z)
                        || (has_ud && grown_ud == cost_ud)
                        || gathered_touching;

    assign odd_root = (updated_root == own_addr) && is_odd_cardinality && !is_touching_boundary;

    // entry takes the root's own verdict, later cycles flood it from neighbours
    assign next_odd_cluster = stage_entry ? odd_root
                                          : (is_odd_cluster || (|neighbor_is_odd_cluster));

    assign grow_now          = (stage == grow_boundary) && stage_entry && is_odd_cluster;
    assign neighbor_increase = grow_now; // one pulse per grow stage

    assign changed = root_changed
                  || ((stage == sync_is_odd_cluster) && (next_odd_cluster != is_odd_cluster));
    assign is_processing = changed || changed_d || msg_busy; // held one extra cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            is_error_syndrome    <= 1'b0;
            is_odd_cardinality   <= 1'b0;
            is_touching_boundary <= 1'b0;
            is_odd_cluster       <= 1'b0;
            grown_z              <= '0;
            grown_ud             <= '0;
            changed_d            <= 1'b0;
        end else begin
            changed_d <= changed;
            case (stage)
                measurement_loading: begin
                    is_error_syndrome    <= init_is_error_syndrome;
                    is_odd_cardinality   <= init_is_error_syndrome; // single-node cluster
                    is_odd_cluster       <= init_is_error_syndrome;
                    is_touching_boundary <= 1'b0;
                    grown_z              <= '0;
                    grown_ud             <= '0;
                end
                spread_cluster: begin
                    is_touching_boundary <= next_touching;
                    is_odd_cardinality   <= is_odd_cardinality ^ gathered_odd;
                end
                grow_boundary: begin
                    if (grow_now) begin
                        if (has_z && grown_z < cost_z)
                            grown_z <= grown_z + cost_t'(1);
                        if (has_ud && grown_ud < cost_ud)
                            grown_ud <= grown_ud + cost_t'(1);
                    end
                end
                sync_is_odd_cluster: is_odd_cluster <= next_odd_cluster;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- direct_msg_unit.sv
`timescale 1ns/1ps
`default_nettype none

module direct_msg_unit #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0,
    parameter int DIRECT_CHANNEL_COUNT = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  protocol_pkg::stage_e            stage,
    input  lattice_pkg::addr_t              new_root,
    input  logic                            root_changed,
    input  logic                            is_error_syndrome,
    input  logic                            is_touching_boundary,
    input  logic                            next_touching,
    input  protocol_pkg::direct_msg_t       direct_in_msgs [DIRECT_CHANNEL_COUNT],
    input  logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_valid,
    output logic [DIRECT_CHANNEL_COUNT-1:0] direct_in_is_taken,
    output protocol_pkg::direct_msg_t       direct_out_msg,
    output logic                            direct_out_valid,
    input  logic                            direct_out_is_full,
    output logic                            gathered_odd,
    output logic                            gathered_touching,
    output logic                            msg_busy
);
    import lattice_pkg::*;
    import protocol_pkg::*;

    localparam addr_t own_addr = make_addr(K, I, J);

    logic                            spreading;
    logic [DIRECT_CHANNEL_COUNT-1:0] matched;    // valid and addressed to this node
    logic [DIRECT_CHANNEL_COUNT-1:0] odd_bits;
    logic [DIRECT_CHANNEL_COUNT-1:0] touch_bits;
    logic                            touch_changed, send_odd, send_touch;
    logic                            generate_msg, delivered;
    logic                            pending;    // own message waiting to leave
    direct_msg_t                     stored_msg;

    assign spreading = (stage == spread_cluster);

    genvar n;
    for (n = 0; n < DIRECT_CHANNEL_COUNT; n++) begin : g_in
        assign matched[n] = spreading && direct_in_valid[n] &&
                            (direct_in_msgs[n].receiver == own_addr);
        assign odd_bits[n]   = direct_in_msgs[n].is_odd_cardinality;
        assign touch_bits[n] = direct_in_msgs[n].is_touching_boundary;
    end

    assign direct_in_is_taken = matched; // others stay in their channel untaken
    assign gathered_odd       = ^(matched & odd_bits);  // odd count of odd senders flips parity
    assign gathered_touching  = |(matched & touch_bits);

    // own message toward the new root
    assign touch_changed = (next_touching != is_touching_boundary);
    assign send_odd      = root_changed && is_error_syndrome;
    assign send_touch    = (root_changed && next_touching) || touch_changed;
    assign generate_msg  = spreading && (root_changed || touch_changed);

    assign direct_out_valid = pending && spreading;
    assign delivered        = direct_out_valid && !direct_out_is_full;
    assign direct_out_msg   = stored_msg;
    assign msg_busy         = pending || (|direct_in_valid);

    always_ff @(posedge clk) begin
        if (generate_msg) begin // newest message replaces an unsent one
            stored_msg.receiver             <= new_root;
            stored_msg.is_odd_cardinality   <= send_odd;
            stored_msg.is_touching_boundary <= send_touch;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            pending <= 1'b0;
        else if (stage == measurement_loading)
            pending <= 1'b0;   // a new syndrome drops stale traffic
        else if (generate_msg)
            pending <= 1'b1;
        else if (delivered)
            pending <= 1'b0;   // accepted when not full
    end

endmodule

`default_nettype wire

//--- root_elect.sv
`timescale 1ns/1ps
`default_nettype none

module root_elect #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0,
    parameter int NEIGHBOR_COUNT = 6
) (
    input  logic                      clk,
    input  logic                      reset,
    input  protocol_pkg::stage_e      stage,
    input  logic                      stage_entry,
    input  logic [NEIGHBOR_COUNT-1:0] neighbor_is_fully_grown,
    input  lattice_pkg::addr_t        neighbor_roots [NEIGHBOR_COUNT],
    output lattice_pkg::addr_t        new_root,
    output logic                      root_changed,
    output lattice_pkg::addr_t        updated_root,
    output lattice_pkg::addr_t        old_root
);
    import lattice_pkg::*;
    import protocol_pkg::*;

    localparam addr_t own_addr = make_addr(K, I, J);
    localparam int depth = $clog2(NEIGHBOR_COUNT);
    localparam int leaves = 1 << depth; // tree padded to a power of two

    // heap layout, node n has children 2n+1 and 2n+2, leaves at the end
    addr_t node_addr  [2*leaves-1];
    logic  node_valid [2*leaves-1];

    genvar n;
    for (n = 0; n < leaves; n++) begin : g_leaf
        if (n < NEIGHBOR_COUNT) begin : g_used
            assign node_valid[leaves-1+n] = neighbor_is_fully_grown[n]; // only grown links count
            assign node_addr[leaves-1+n]  = neighbor_roots[n];
        end else begin : g_pad
            assign node_valid[leaves-1+n] = 1'b0;
            assign node_addr[leaves-1+n]  = updated_root;
        end
    end

    for (n = 0; n < leaves-1; n++) begin : g_node
        logic pick_left;
        assign pick_left = node_valid[2*n+1] &&
                           (!node_valid[2*n+2] || node_addr[2*n+1] <= node_addr[2*n+2]);
        assign node_valid[n] = node_valid[2*n+1] | node_valid[2*n+2];
        assign node_addr[n]  = pick_left ? node_addr[2*n+1] : node_addr[2*n+2];
    end

    // own root is the default, a neighbour must beat it strictly
    assign new_root = (node_valid[0] && node_addr[0] < updated_root) ? node_addr[0] : updated_root;
    assign root_changed = (stage == spread_cluster) && (new_root != updated_root);

    always_ff @(posedge clk) begin
        if (reset) begin
            updated_root <= own_addr;
            old_root     <= own_addr;
        end else begin
            case (stage)
                measurement_loading: begin
                    updated_root <= own_addr; // every node starts as its own root
                    old_root     <= own_addr;
                end
                spread_cluster: updated_root <= new_root; // commit election every cycle
                sync_is_odd_cluster: begin
                    if (stage_entry)
                        old_root <= updated_root; // published to neighbours next round
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  protocol_pkg::stage_e stage_in,
    output protocol_pkg::stage_e stage,
    output logic                 stage_entry
);
    import protocol_pkg::*;

    stage_e last_stage; // stage seen one cycle before

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= idle;
            last_stage <= idle;
        end else begin
            stage <= stage_in; // one cycle of latency on every stage change
            // loading hands over as idle, so an idle right after it is no entry
            last_stage <= (stage == measurement_loading) ? idle : stage;
        end
    end

    assign stage_entry = (stage != last_stage); // first registered cycle of a stage

endmodule

`default_nettype wire

//--- protocol_pkg.sv
`default_nettype none

package protocol_pkg;

    // global decoder stage, broadcast to every node
    typedef enum logic [2:0] {
        idle                = 3'd0,
        spread_cluster      = 3'd1,
        grow_boundary       = 3'd2,
        sync_is_odd_cluster = 3'd3,
        measurement_loading = 3'd4
    } stage_e;

    // message sent toward the root a node has joined
    typedef struct packed {
        lattice_pkg::addr_t receiver;
        logic               is_odd_cardinality;   // sender flips the root cardinality
        logic               is_touching_boundary; // sender reached a boundary
    } direct_msg_t;

endpackage

`default_nettype wire

//--- lattice_pkg.sv
`default_nettype none

package lattice_pkg;

    typedef logic [4:0] coord_t; // i or j inside one measurement round
    typedef logic [7:0] layer_t; // k, the measurement round

    // field order sets the root priority, smaller packed value wins
    typedef struct packed {
        layer_t k;
        coord_t i;
        coord_t j;
    } addr_t;

    typedef logic [1:0] cost_t; // boundary cost and boundary growth counter

    // builds a node address from its lattice coordinates
    function automatic addr_t make_addr(input int k, input int i, input int j);
        addr_t a;
        a.k = layer_t'(k);
        a.i = coord_t'(i);
        a.j = coord_t'(j);
        return a;
    endfunction

endpackage

`default_nettype wire
